// ==== logic/controlPkg.sv ====
`default_nettype none

package controlPkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [2:0] aluOpT;
	typedef logic [1:0] pcSrcT;
	typedef logic [1:0] memToRegT;
	typedef logic [1:0] aluSrcBT;
	typedef logic [3:0] instrClassT;

	typedef enum logic [5:0] {
		Reset, Busca, Wait, Write, Decode,
		LwOrSw, Lw, WaitLw, Wbs, Sw,
		AddLoad, Add, Sub, And, Xor, AddComp,
		Break, Nop, Jump, Beq, Bne, Lui, Overflow
	} stateT;

	localparam opcodeT OpRtype = 6'h00;
	localparam opcodeT OpJump = 6'h02;
	localparam opcodeT OpBeq = 6'h04;
	localparam opcodeT OpBne = 6'h05;
	localparam opcodeT OpLui = 6'h0F;
	localparam opcodeT OpLw = 6'h23;
	localparam opcodeT OpSw = 6'h2B;

	localparam functT FnAdd = 6'h20;
	localparam functT FnSub = 6'h22;
	localparam functT FnAnd = 6'h24;
	localparam functT FnXor = 6'h26;
	localparam functT FnBreak = 6'h0D;

	localparam instrClassT ClsJump = 4'h0;
	localparam instrClassT ClsBeq = 4'h1;
	localparam instrClassT ClsBne = 4'h2;
	localparam instrClassT ClsLui = 4'h3;
	localparam instrClassT ClsLw = 4'h4;
	localparam instrClassT ClsSw = 4'h5;
	localparam instrClassT ClsIllegal = 4'h7;
	localparam instrClassT ClsRtype = 4'h8; // Flag bit, set in every funct class
	localparam instrClassT ClsAdd = 4'h8;
	localparam instrClassT ClsSub = 4'h9;
	localparam instrClassT ClsAnd = 4'hA;
	localparam instrClassT ClsXor = 4'hB;
	localparam instrClassT ClsBreak = 4'hC;

	localparam aluOpT AluLoad = 3'd0;
	localparam aluOpT AluAdd = 3'd1;
	localparam aluOpT AluSub = 3'd2;
	localparam aluOpT AluAnd = 3'd3;
	localparam aluOpT AluXor = 3'd6;

	localparam pcSrcT PcAlu = 2'd0;
	localparam pcSrcT PcAluOut = 2'd1; // Branch target
	localparam pcSrcT PcJump = 2'd2;
	localparam pcSrcT PcEpc = 2'd3;

	localparam memToRegT WbAlu = 2'd0;
	localparam memToRegT WbMem = 2'd1;
	localparam memToRegT WbLui = 2'd2;

	localparam aluSrcBT SrcBReg = 2'd0;
	localparam aluSrcBT SrcBFour = 2'd1;
	localparam aluSrcBT SrcBImm = 2'd2;
	localparam aluSrcBT SrcBBranch = 2'd3;

endpackage

`default_nettype wire

// ==== logic/opcodeDecoder.sv ====
`default_nettype none

module opcodeDecoder (
	input controlPkg::opcodeT OPcode,
	input controlPkg::functT Funct,
	output controlPkg::instrClassT instrClass
);
	import controlPkg::*;

	always_comb begin
		case (OPcode)
			OpRtype: begin
				case (Funct)
					FnAdd: begin
						instrClass = ClsAdd;
					end
					FnSub: begin
						instrClass = ClsSub;
					end
					FnAnd: begin
						instrClass = ClsAnd;
					end
					FnXor: begin
						instrClass = ClsXor;
					end
					FnBreak: begin
						instrClass = ClsBreak;
					end
					default: begin
						instrClass = ClsRtype | ClsIllegal; // Funct 0 lands here too
					end
				endcase
			end
			OpJump: begin
				instrClass = ClsJump;
			end
			OpBeq: begin
				instrClass = ClsBeq;
			end
			OpBne: begin
				instrClass = ClsBne;
			end
			OpLui: begin
				instrClass = ClsLui;
			end
			OpLw: begin
				instrClass = ClsLw;
			end
			OpSw: begin
				instrClass = ClsSw;
			end
			default: begin
				instrClass = ClsIllegal; // Unknown opcode
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/stateSequencer.sv ====
`default_nettype none

module stateSequencer (
	input wire logic clock,
	input wire logic reset,
	input controlPkg::instrClassT instrClass,
	input wire logic sinalOverflow,
	output controlPkg::stateT state
);
	import controlPkg::*;

	stateT nextState;
	logic isRtype;

	assign isRtype = (instrClass & ClsRtype) == ClsRtype;

	// State changes on the falling edge, outputs settle by the rising edge
	always_ff @(negedge clock) begin
		if (reset) begin
			state <= Reset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = Busca;
		case (state)
			Reset: begin
				nextState = Busca;
			end
			Busca: begin
				nextState = Wait;
			end
			Wait: begin
				nextState = Write;
			end
			Write: begin
				nextState = Decode;
			end
			Decode: begin
				case (instrClass)
					ClsJump: nextState = Jump;
					ClsBeq: nextState = Beq;
					ClsBne: nextState = Bne;
					ClsLui: nextState = Lui;
					ClsLw, ClsSw: nextState = LwOrSw;
					default: nextState = isRtype ? AddLoad : Nop;
				endcase
			end
			LwOrSw: begin
				nextState = (instrClass == ClsSw) ? Sw : Lw;
			end
			Lw: begin
				nextState = WaitLw;
			end
			WaitLw: begin
				nextState = Wbs;
			end
			AddLoad: begin
				case (instrClass)
					ClsAdd: nextState = Add;
					ClsSub: nextState = Sub;
					ClsAnd: nextState = And;
					ClsXor: nextState = Xor;
					ClsBreak: nextState = Break;
					default: nextState = Nop; // Unknown funct
				endcase
			end
			Add: begin
				nextState = sinalOverflow ? Overflow : AddComp;
			end
			Sub, And, Xor: begin
				nextState = AddComp;
			end
			Break: begin
				nextState = Break; // Held until reset
			end
			default: begin
				nextState = Busca;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/controlOutputs.sv ====
`default_nettype none

module controlOutputs (
	input controlPkg::stateT state,
	output controlPkg::pcSrcT SrcPC,
	output logic ULASrcA,
	output controlPkg::aluSrcBT ULASrcB,
	output logic EscReg,
	output logic RegDst,
	output logic IREsc,
	output controlPkg::memToRegT Mem2Reg,
	output logic WriteMem,
	output logic StoreMem,
	output controlPkg::aluOpT ULAOp,
	output logic IorD,
	output logic PCWri,
	output logic PCWriCond,
	output logic ALUOutCtrl,
	output logic RegAload,
	output logic RegBload,
	output logic EPCWrite
);
	import controlPkg::*;

	always_comb begin
		SrcPC = PcAlu;
		ULASrcA = 1'b0;
		ULASrcB = SrcBReg;
		EscReg = 1'b0;
		RegDst = 1'b0;
		IREsc = 1'b0;
		Mem2Reg = WbAlu;
		WriteMem = 1'b0; // Memory reads unless this is high
		StoreMem = 1'b0;
		ULAOp = AluLoad;
		IorD = 1'b0;
		PCWri = 1'b0;
		PCWriCond = 1'b0;
		ALUOutCtrl = 1'b0;
		RegAload = 1'b0;
		RegBload = 1'b0;
		EPCWrite = 1'b0;
		case (state)
			Busca: begin
				ULASrcB = SrcBFour; // PC + 4
				ULAOp = AluAdd;
				PCWri = 1'b1;
			end
			Wait: begin
				ULASrcB = SrcBFour;
			end
			Write: begin
				ULASrcB = SrcBFour;
				IREsc = 1'b1;
				ULAOp = AluAdd;
			end
			Decode: begin
				ULASrcB = SrcBBranch; // Branch target computed early
				ULAOp = AluAdd;
				ALUOutCtrl = 1'b1;
			end
			LwOrSw, Lw, WaitLw, Wbs: begin
				ULASrcA = 1'b1;
				ULASrcB = SrcBImm;
				ULAOp = AluAdd;
				IorD = state != LwOrSw;
				ALUOutCtrl = (state == LwOrSw) || (state == WaitLw);
				RegAload = state == WaitLw;
				EscReg = state == Wbs;
				StoreMem = state == Wbs;
				Mem2Reg = (state == Wbs) ? WbMem : WbAlu;
			end
			Sw: begin
				ULASrcA = 1'b1;
				IREsc = 1'b1;
				WriteMem = 1'b1;
				ULAOp = AluAdd;
				IorD = 1'b1;
			end
			AddLoad, Add, Sub, And, Xor, AddComp: begin
				ULASrcA = 1'b1;
				RegDst = 1'b1;
				Mem2Reg = WbMem;
				ALUOutCtrl = state != AddComp;
				EscReg = state == AddComp;
				RegAload = state == AddLoad;
				RegBload = state == AddLoad;
				case (state)
					AddLoad: ULAOp = AluLoad;
					Sub: ULAOp = AluSub;
					And: ULAOp = AluAnd;
					Xor: ULAOp = AluXor;
					default: ULAOp = AluAdd;
				endcase
			end
			Break: begin
				ULASrcB = SrcBFour;
				ULAOp = AluSub;
			end
			Nop: begin
				ULAOp = AluSub;
			end
			Jump: begin
				SrcPC = PcJump;
				ULASrcB = SrcBFour;
				PCWri = 1'b1;
				ALUOutCtrl = 1'b1;
			end
			Beq, Bne: begin
				SrcPC = PcAluOut;
				ULASrcA = 1'b1;
				ULAOp = AluSub; // Compare by subtraction
				PCWriCond = 1'b1;
				PCWri = state == Bne;
			end
			Lui: begin
				ULASrcB = SrcBFour;
				EscReg = 1'b1;
				Mem2Reg = WbLui;
				StoreMem = 1'b1;
				ULAOp = AluAdd;
			end
			Overflow: begin
				SrcPC = PcEpc; // Jump to exception handler
				ULASrcB = SrcBFour;
				Mem2Reg = WbMem;
				ULAOp = AluSub;
				PCWri = 1'b1;
				EPCWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`default_nettype none

module controlUnit (
	input wire logic clock,
	input wire logic reset,
	input wire logic sinalOverflow,
	input controlPkg::opcodeT OPcode,
	input controlPkg::functT Funct,
	output controlPkg::pcSrcT SrcPC,
	output logic ULASrcA,
	output controlPkg::aluSrcBT ULASrcB,
	output logic EscReg,
	output logic RegDst,
	output logic IREsc,
	output controlPkg::memToRegT Mem2Reg,
	output logic WriteMem,
	output logic StoreMem,
	output controlPkg::aluOpT ULAOp,
	output logic IorD,
	output logic PCWri,
	output logic PCWriCond,
	output logic ALUOutCtrl,
	output logic RegAload,
	output logic RegBload,
	output logic EPCWrite,
	output controlPkg::stateT stateout
);
	import controlPkg::*;

	instrClassT instrClass;
	stateT state;

	assign stateout = state;

	opcodeDecoder decoder0 (
		.OPcode(OPcode),
		.Funct(Funct),
		.instrClass(instrClass)
	);

	stateSequencer sequencer0 (
		.clock(clock),
		.reset(reset),
		.instrClass(instrClass),
		.sinalOverflow(sinalOverflow),
		.state(state)
	);

	controlOutputs outputs0 (
		.state(state),
		.SrcPC(SrcPC),
		.ULASrcA(ULASrcA),
		.ULASrcB(ULASrcB),
		.EscReg(EscReg),
		.RegDst(RegDst),
		.IREsc(IREsc),
		.Mem2Reg(Mem2Reg),
		.WriteMem(WriteMem),
		.StoreMem(StoreMem),
		.ULAOp(ULAOp),
		.IorD(IorD),
		.PCWri(PCWri),
		.PCWriCond(PCWriCond),
		.ALUOutCtrl(ALUOutCtrl),
		.RegAload(RegAload),
		.RegBload(RegBload),
		.EPCWrite(EPCWrite)
	);

endmodule

`default_nettype wire

// ==== tb/controlUnit_chk.sv ====
`default_nettype none

module controlUnitChk (
	input wire logic clock,
	input wire logic reset,
	input wire logic WriteMem,
	input wire logic EscReg,
	input wire logic EPCWrite,
	input wire controlPkg::stateT state
);
	import controlPkg::*;

	// Memory write and register write never share a state
	noWriteClash: assert property (@(posedge clock) disable iff (reset)
		!(WriteMem && EscReg))
		else $error("WriteMem and EscReg high together");

	epcOnlyInOverflow: assert property (@(posedge clock) disable iff (reset)
		EPCWrite |-> state == Overflow)
		else $error("EPCWrite high outside Overflow");

	// Halt is left only through reset
	breakHolds: assert property (@(posedge clock)
		state == Break |=> (state == Break || reset))
		else $error("Break left without reset");

endmodule

bind controlUnit controlUnitChk chk0 (
	.clock(clock),
	.reset(reset),
	.WriteMem(WriteMem),
	.EscReg(EscReg),
	.EPCWrite(EPCWrite),
	.state(stateout)
);

`default_nettype wire

// ==== tb/controlUnitTb.sv ====
`default_nettype none

module controlUnitTb;
	import controlPkg::*;

	localparam int NumInstr = 300;
	localparam int CycleLimit = NumInstr * 9 + 200; // Longest path is 8 cycles

	logic clock;
	logic reset;
	logic sinalOverflow;
	opcodeT OPcode;
	functT Funct;
	pcSrcT SrcPC;
	logic ULASrcA;
	aluSrcBT ULASrcB;
	logic EscReg;
	logic RegDst;
	logic IREsc;
	memToRegT Mem2Reg;
	logic WriteMem;
	logic StoreMem;
	aluOpT ULAOp;
	logic IorD;
	logic PCWri;
	logic PCWriCond;
	logic ALUOutCtrl;
	logic RegAload;
	logic RegBload;
	logic EPCWrite;
	stateT stateout;

	stateT expState; // Model's view of the current state
	logic modelValid;
	logic breakNext;
	int cycles;
	int checks;
	int issued;
	int phase;
	int curCat;
	int errIdx;
	int errs[7];
	int tally[7];
	int totalErr;

	controlUnit dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Cycle counter guards against a stuck run
	initial begin
		cycles = 0;
		while (cycles < CycleLimit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CycleLimit);
		$display("Result: FAILED");
		$finish;
	end

	// Next state from the opcode and funct fields
	function automatic stateT modelNext(stateT s, opcodeT op, functT fn, logic ovf);
		case (s)
			Reset: return Busca;
			Busca: return Wait;
			Wait: return Write;
			Write: return Decode;
			Decode: begin
				case (op)
					OpJump: return Jump;
					OpBeq: return Beq;
					OpBne: return Bne;
					OpLui: return Lui;
					OpLw, OpSw: return LwOrSw;
					OpRtype: return AddLoad;
					default: return Nop;
				endcase
			end
			LwOrSw: return (op == OpSw) ? Sw : Lw;
			Lw: return WaitLw;
			WaitLw: return Wbs;
			AddLoad: begin
				case (fn)
					FnAdd: return Add;
					FnSub: return Sub;
					FnAnd: return And;
					FnXor: return Xor;
					FnBreak: return Break;
					default: return Nop;
				endcase
			end
			Add: return ovf ? Overflow : AddComp;
			Sub, And, Xor: return AddComp;
			Break: return Break;
			default: return Busca;
		endcase
	endfunction

	// Which behavior an instruction's errors count against
	function automatic int categoryOf(opcodeT op, functT fn, logic ovf);
		if (op == OpRtype && fn == FnAdd && ovf) return 3;
		if (!(op inside {OpRtype, OpJump, OpBeq, OpBne, OpLui, OpLw, OpSw})) return 4;
		if (op == OpRtype && !(fn inside {FnAdd, FnSub, FnAnd, FnXor, FnBreak})) return 4;
		if (op inside {OpSw, OpLw, OpBeq, OpBne, OpJump}) return 5;
		return 2;
	endfunction

	task automatic checkVal(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s = %h, expected %h in state %s (cycle %0d)",
				name, got, exp, expState.name(), cycles);
			errs[errIdx]++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkVal(name, 8'(got), 8'(exp));
	endtask

	task automatic checkOutputs();
		stateT s;
		s = expState;
		checkVal("stateout", 8'(stateout), 8'(s));
		checkBit("PCWri", PCWri, s inside {Busca, Jump, Bne, Overflow});
		checkBit("PCWriCond", PCWriCond, s inside {Beq, Bne});
		checkBit("IREsc", IREsc, s inside {Write, Sw});
		checkBit("WriteMem", WriteMem, s == Sw);
		checkBit("EscReg", EscReg, s inside {Wbs, AddComp, Lui});
		checkBit("EPCWrite", EPCWrite, s == Overflow);
		checkBit("RegAload", RegAload, s inside {AddLoad, WaitLw});
		checkBit("RegBload", RegBload, s == AddLoad);
		checkBit("IorD", IorD, s inside {Lw, WaitLw, Wbs, Sw}); // Data address from ALUOut
		if (s == Overflow) checkVal("SrcPC", 8'(SrcPC), 8'(PcEpc));
		else if (s == Jump) checkVal("SrcPC", 8'(SrcPC), 8'(PcJump));
		else if (s inside {Beq, Bne}) checkVal("SrcPC", 8'(SrcPC), 8'(PcAluOut));
		else checkBit("SrcPC is PcEpc", SrcPC == PcEpc, 1'b0);
		if (s == Sub) checkVal("ULAOp", 8'(ULAOp), 8'(AluSub));
		if (s == And) checkVal("ULAOp", 8'(ULAOp), 8'(AluAnd));
		if (s == Xor) checkVal("ULAOp", 8'(ULAOp), 8'(AluXor));
		if (s == Wbs) checkVal("Mem2Reg", 8'(Mem2Reg), 8'(WbMem));
		if (s == Lui) checkVal("Mem2Reg", 8'(Mem2Reg), 8'(WbLui));
		if (s == AddComp) checkBit("RegDst", RegDst, 1'b1); // rd for R-type
		if (s inside {Wbs, Lui}) checkBit("RegDst", RegDst, 1'b0);
		if (s inside {Busca, Decode}) checkBit("ULASrcA", ULASrcA, 1'b0); // PC into the ALU
		if (s inside {LwOrSw, Add, Sub, And, Xor, Beq, Bne}) checkBit("ULASrcA", ULASrcA, 1'b1);
		if (s == Busca) checkVal("ULASrcB", 8'(ULASrcB), 8'(SrcBFour));
		if (s == Decode) checkVal("ULASrcB", 8'(ULASrcB), 8'(SrcBBranch));
		if (s == LwOrSw) checkVal("ULASrcB", 8'(ULASrcB), 8'(SrcBImm));
		if (s inside {Add, Sub, And, Xor, Beq, Bne}) checkVal("ULASrcB", 8'(ULASrcB), 8'(SrcBReg));
		if (s == Decode) checkBit("ALUOutCtrl", ALUOutCtrl, 1'b1);
		if (s == Reset) begin
			checkBit("StoreMem", StoreMem, 1'b0);
			checkBit("ALUOutCtrl", ALUOutCtrl, 1'b0);
		end
	endtask

	task automatic pickInstr();
		int r;
		r = $urandom % 16;
		case (r)
			0, 1, 2, 3, 4: OPcode = OpRtype;
			5: OPcode = OpJump;
			6: OPcode = OpBeq;
			7: OPcode = OpBne;
			8: OPcode = OpLui;
			9, 10: OPcode = OpLw;
			11, 12: OPcode = OpSw;
			default: OPcode = opcodeT'($urandom);
		endcase
		r = $urandom % 8;
		case (r)
			0, 1: Funct = FnAdd;
			2: Funct = FnSub;
			3: Funct = FnAnd;
			4: Funct = FnXor;
			5: Funct = 6'h00;
			default: Funct = functT'($urandom);
		endcase
		if (Funct == FnBreak) Funct = 6'h00; // Break only at the end
		sinalOverflow = ($urandom % 3) == 0;
		if (breakNext) begin
			OPcode = OpRtype;
			Funct = FnBreak;
			breakNext = 1'b0;
		end
		curCat = categoryOf(OPcode, Funct, sinalOverflow);
		tally[curCat]++;
		issued++;
	endtask

	// One clock: check at the rising edge, then drive and advance the model
	task automatic step(input logic rst);
		@(posedge clock);
		errIdx = (phase != 0) ? phase : curCat;
		if (modelValid) checkOutputs();
		#1;
		reset = rst;
		if (!rst && expState == Busca && (issued < NumInstr || breakNext)) pickInstr();
		expState = rst ? Reset : modelNext(expState, OPcode, Funct, sinalOverflow);
		modelValid = 1'b1;
	endtask

	task automatic report(input int t, input string what);
		$display("Test %0d %s: %s, %0d errors", t, what, (errs[t] == 0) ? "ok" : "failed", errs[t]);
	endtask

	initial begin
		reset = 1'b1;
		sinalOverflow = 1'b0;
		OPcode = OpRtype;
		Funct = 6'h00;
		expState = Reset;
		modelValid = 1'b0;
		breakNext = 1'b0;
		checks = 0;
		issued = 0;
		curCat = 2;
		void'($urandom(32'h3298_c2f4));

		phase = 1;
		repeat (8) step(1'b1);
		repeat (5) step(1'b0);
		report(1, "reset and fetch sequence");

		phase = 0;
		while (issued < NumInstr) step(1'b0);
		while (expState != Busca) step(1'b0);
		report(2, $sformatf("class paths, %0d instr", tally[2]));
		report(3, $sformatf("add overflow, %0d instr", tally[3]));
		report(4, $sformatf("unknown opcode or funct, %0d instr", tally[4]));
		report(5, $sformatf("memory, branch and jump, %0d instr", tally[5]));

		phase = 6;
		breakNext = 1'b1;
		step(1'b0);
		while (expState != Break) step(1'b0);
		repeat (10) step(1'b0);
		repeat (8) step(1'b1);
		repeat (5) step(1'b0); // Fetch restarts after reset
		report(6, "break hold and restart");

		totalErr = 0;
		foreach (errs[i]) totalErr += errs[i];
		$display("Checks: %0d, errors: %0d, instructions: %0d", checks, totalErr, issued);
		if (totalErr == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/controlPkg.sv
logic/opcodeDecoder.sv
logic/stateSequencer.sv
logic/controlOutputs.sv
logic/controlUnit.sv
tb/controlUnit_chk.sv
tb/controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= controlUnitTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
